//--- Makefile
TOP := line_encoder_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir sim.log

//--- compile.f
hw/line_code_pkg.sv
hw/symbol_if.sv
hw/enc_5b6b.sv
hw/enc_3b4b.sv
hw/symbol_fifo.sv
hw/serializer.sv
hw/line_encoder_top.sv
verification/line_encoder_tb.sv

//--- hw/enc_3b4b.sv
`timescale 1ns/10ps

module enc_3b4b (
    input  logic                 clk,
    input  logic                 rst_n,
    input  line_code_pkg::half_t half,
    input  logic                 half_valid,
    symbol_if.enc                sym
);

    logic [line_code_pkg::SUB4_W-1:0] base4;  // fghj at negative rd_mid
    logic                             alt4;   // complemented at positive rd_mid
    logic [line_code_pkg::SUB4_W-1:0] fghj;

    // 3b/4b table, f in bit 3
    always_comb begin
        case (half.hgf)
            3'd0:    {alt4, base4} = 5'b1_1011;
            3'd1:    {alt4, base4} = 5'b0_1001;
            3'd2:    {alt4, base4} = 5'b0_0101;
            3'd3:    {alt4, base4} = 5'b1_1100;
            3'd4:    {alt4, base4} = 5'b1_1101;
            3'd5:    {alt4, base4} = 5'b0_1010;
            3'd6:    {alt4, base4} = 5'b0_0110;
            default: begin
                if (half.use_a7) begin
                    {alt4, base4} = 5'b1_0111;  // A7
                end else begin
                    {alt4, base4} = 5'b1_1110;  // P7
                end
            end
        endcase
    end

    // K28.1, .2, .5 and .6 invert the balanced data forms
    // when the 6b block left the line negative
    always_comb begin
        if (alt4) begin
            fghj = half.rd_mid ? ~base4 : base4;
        end else if (half.k) begin
            fghj = half.rd_mid ? base4 : ~base4;
        end else begin
            fghj = base4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym.push <= 1'b0;
        end else begin
            sym.push <= half_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (half_valid) begin
            sym.wr_symbol <= {half.sub6, fghj}; // a goes out first
        end
    end

endmodule

//--- hw/enc_5b6b.sv
`timescale 1ns/10ps

module enc_5b6b (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 din_valid,  // one-cycle strobe
    input  logic [7:0]           din,        // HGF EDCBA
    input  logic                 k,          // control character request
    output line_code_pkg::half_t half,
    output logic                 half_valid
);

    logic [4:0]               x;         // EDCBA
    logic [2:0]               y;         // HGF
    logic                     is_k28;
    logic [5:0]               code6;     // form used at negative disparity
    logic                     alt6;      // code has a complement form
    logic [5:0]               sub6;
    logic                     rd;        // running disparity, 1 = positive
    logic                     rd_mid;
    logic                     rd_end;
    logic                     use_a7;
    line_code_pkg::half_t     half_next;

    assign x      = din[4:0];
    assign y      = din[7:5];
    assign is_k28 = k && (x == line_code_pkg::K28_X); // other K values go out as data

    // 5b/6b table, abcdei with a in bit 5
    always_comb begin
        case (x)
            5'd0:    {alt6, code6} = 7'b1_100111;
            5'd1:    {alt6, code6} = 7'b1_011101;
            5'd2:    {alt6, code6} = 7'b1_101101;
            5'd3:    {alt6, code6} = 7'b0_110001;
            5'd4:    {alt6, code6} = 7'b1_110101;
            5'd5:    {alt6, code6} = 7'b0_101001;
            5'd6:    {alt6, code6} = 7'b0_011001;
            5'd7:    {alt6, code6} = 7'b1_111000; // balanced but still alternates
            5'd8:    {alt6, code6} = 7'b1_111001;
            5'd9:    {alt6, code6} = 7'b0_100101;
            5'd10:   {alt6, code6} = 7'b0_010101;
            5'd11:   {alt6, code6} = 7'b0_110100;
            5'd12:   {alt6, code6} = 7'b0_001101;
            5'd13:   {alt6, code6} = 7'b0_101100;
            5'd14:   {alt6, code6} = 7'b0_011100;
            5'd15:   {alt6, code6} = 7'b1_010111;
            5'd16:   {alt6, code6} = 7'b1_011011;
            5'd17:   {alt6, code6} = 7'b0_100011;
            5'd18:   {alt6, code6} = 7'b0_010011;
            5'd19:   {alt6, code6} = 7'b0_110010;
            5'd20:   {alt6, code6} = 7'b0_001011;
            5'd21:   {alt6, code6} = 7'b0_101010;
            5'd22:   {alt6, code6} = 7'b0_011010;
            5'd23:   {alt6, code6} = 7'b1_111010;
            5'd24:   {alt6, code6} = 7'b1_110011;
            5'd25:   {alt6, code6} = 7'b0_100110;
            5'd26:   {alt6, code6} = 7'b0_010110;
            5'd27:   {alt6, code6} = 7'b1_110110;
            5'd28:   {alt6, code6} = 7'b0_001110;
            5'd29:   {alt6, code6} = 7'b1_101110;
            5'd30:   {alt6, code6} = 7'b1_011110;
            default: {alt6, code6} = 7'b1_101011; // D.31
        endcase
        if (is_k28) begin
            {alt6, code6} = 7'b1_001111;
        end
    end

    // positive disparity takes the complement
    assign sub6   = (alt6 && rd) ? ~code6 : code6;
    assign rd_mid = rd ^ ($countones(sub6) != 3);

    // x.A7 avoids a run of five equal bits across the sub-block edge
    assign use_a7 = (y == 3'd7) &&
                    (is_k28 ||
                     (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                     (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

    // 3b codes for y = 0, 4 and 7 are unbalanced
    assign rd_end = rd_mid ^ (y == 3'd0 || y == 3'd4 || y == 3'd7);

    always_comb begin
        half_next.sub6   = sub6;
        half_next.hgf    = y;
        half_next.k      = is_k28;
        half_next.rd_mid = rd_mid;
        half_next.use_a7 = use_a7;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd         <= 1'b0; // starts negative
            half_valid <= 1'b0;
        end else begin
            half_valid <= din_valid;
            if (din_valid) begin
                rd <= rd_end;
            end
        end
    end

    // holds between strobes
    always_ff @(posedge clk) begin
        if (din_valid) begin
            half <= half_next;
        end
    end

endmodule

//--- hw/line_code_pkg.sv
package line_code_pkg;

    // symbol and sub-block widths
    localparam int SYMBOL_W = 10;
    localparam int SUB6_W   = 6;
    localparam int SUB4_W   = 4;

    // din[4:0] value that marks K28.y when k is high
    localparam logic [4:0] K28_X = 5'd28;

    // hand-off from the 5b/6b stage to the 3b/4b stage, 12 bits
    typedef struct packed {
        logic [SUB6_W-1:0] sub6;   // abcdei, a in the msb
        logic [2:0]        hgf;    // upper input bits, y of D.x.y
        logic              k;      // K28 control character
        logic              rd_mid; // disparity after abcdei, 1 = positive
        logic              use_a7; // alternate x.A7 form required
    } half_t;

    // serializer states
    typedef enum logic {
        SER_IDLE,
        SER_SHIFT
    } ser_state_t;

endpackage

//--- hw/line_encoder_top.sv
`timescale 1ns/10ps

module line_encoder_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       din_valid,  // one-cycle strobe, only while busy is low
    input  logic [7:0] din,
    input  logic       k,
    output logic       busy,
    output logic       ser_valid,  // high on every serial bit
    output logic       ser_out
);

    line_code_pkg::half_t half;
    logic                 half_valid;

    symbol_if symbol_ch ();

    // stage 1, owns the running disparity
    enc_5b6b u_enc_5b6b (
        .clk        (clk),
        .rst_n      (rst_n),
        .din_valid  (din_valid),
        .din        (din),
        .k          (k),
        .half       (half),
        .half_valid (half_valid)
    );

    // stage 2, pushes the full symbol
    enc_3b4b u_enc_3b4b (
        .clk        (clk),
        .rst_n      (rst_n),
        .half       (half),
        .half_valid (half_valid),
        .sym        (symbol_ch.enc)
    );

    symbol_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_symbol_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .busy  (busy),
        .sym   (symbol_ch.buff)
    );

    serializer u_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .ser_valid (ser_valid),
        .ser_out   (ser_out),
        .sym       (symbol_ch.ser)
    );

endmodule

//--- hw/serializer.sv
`timescale 1ns/10ps

module serializer (
    input  logic  clk,
    input  logic  rst_n,
    output logic  ser_valid,
    output logic  ser_out,
    symbol_if.ser sym
);

    line_code_pkg::ser_state_t                state;
    logic [line_code_pkg::SYMBOL_W-1:0]       shreg;
    logic [3:0]                               bit_cnt;   // 0..9 within a symbol
    logic                                     last_bit;

    assign last_bit = (state == line_code_pkg::SER_SHIFT) && (bit_cnt == 4'd9);

    // take a symbol when idle, or back to back at the tenth bit
    assign sym.pop = !sym.empty && ((state == line_code_pkg::SER_IDLE) || last_bit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= line_code_pkg::SER_IDLE;
            shreg   <= '0;
            bit_cnt <= '0;
        end else if (sym.pop) begin
            state   <= line_code_pkg::SER_SHIFT;
            shreg   <= sym.rd_symbol;
            bit_cnt <= '0;
        end else if (state == line_code_pkg::SER_SHIFT) begin
            shreg <= {shreg[line_code_pkg::SYMBOL_W-2:0], 1'b0};
            if (last_bit) begin
                state   <= line_code_pkg::SER_IDLE; // fifo ran dry
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // bit a first
    assign ser_out   = shreg[line_code_pkg::SYMBOL_W-1];
    assign ser_valid = (state == line_code_pkg::SER_SHIFT);

endmodule

//--- hw/symbol_fifo.sv
`timescale 1ns/10ps

module symbol_fifo #(
    parameter int FIFO_DEPTH = 8  // power of two, 4 or more
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  busy,
    symbol_if.buff sym
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] DEPTH_C = FIFO_DEPTH[AW:0];
    localparam logic [AW:0] BUSY_LVL = DEPTH_C - 3; // two in flight plus the next strobe

    logic [line_code_pkg::SYMBOL_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]                      wr_ptr;
    logic [AW-1:0]                      rd_ptr;
    logic [AW:0]                        count;
    logic                               full;
    logic                               do_push;
    logic                               do_pop;

    assign full    = (count == DEPTH_C);
    assign do_push = sym.push && !full;
    assign do_pop  = sym.pop && !sym.empty;   // pop on empty is dropped

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= sym.wr_symbol;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign sym.rd_symbol = mem[rd_ptr];   // fall-through head
    assign sym.empty     = (count == '0);
    assign busy          = (count > BUSY_LVL);

endmodule

//--- hw/symbol_if.sv
`timescale 1ns/10ps

interface symbol_if;

    logic                              push;      // one-cycle write strobe
    logic [line_code_pkg::SYMBOL_W-1:0] wr_symbol; // abcdei fghj
    logic                              pop;       // removes head when not empty
    logic [line_code_pkg::SYMBOL_W-1:0] rd_symbol; // fall-through head
    logic                              empty;

    // encoder side, writes finished symbols
    modport enc (
        output push,
        output wr_symbol
    );

    // symbol buffer
    modport buff (
        input  push,
        input  wr_symbol,
        input  pop,
        output rd_symbol,
        output empty
    );

    // serializer side
    modport ser (
        output pop,
        input  rd_symbol,
        input  empty
    );

endinterface

//--- verification/line_encoder_tb.sv
`timescale 1ns/10ps

module line_encoder_tb;

    localparam int CLK_HALF   = 4;
    localparam int N_TABLE    = 10;
    localparam int N_RANDOM   = 200;
    // twelve cycles per character plus reset and slack
    localparam int TIMEOUT_NS = (N_TABLE + N_RANDOM) * 12 * 8 + 16 * 8 + 2000;

    typedef struct packed {
        logic [7:0] b;
        logic       kk;
        logic [3:0] gap;   // idle cycles after the strobe
        logic [9:0] sym;   // abcdei fghj
    } entry_t;

    // disparity carries over from entry to entry and the line starts at rd-
    localparam entry_t TABLE [N_TABLE] = '{
        '{8'h00, 1'b0, 4'd0,  10'h274},  // D.0.0 back to rd-
        '{8'hB5, 1'b0, 4'd3,  10'h2AA},  // D.21.5
        '{8'hF1, 1'b0, 4'd0,  10'h237},  // D.17.7 A7 ends rd+
        '{8'h63, 1'b0, 4'd12, 10'h313},  // D.3.3
        '{8'hBC, 1'b1, 4'd1,  10'h305},  // K28.5 ends rd-
        '{8'h3C, 1'b1, 4'd0,  10'h0F9},  // K28.1 ends rd+
        '{8'hFC, 1'b1, 4'd0,  10'h307},  // K28.7
        '{8'h9F, 1'b0, 4'd5,  10'h14D},  // D.31.4
        '{8'hEB, 1'b0, 4'd0,  10'h348},  // D.11.7 A7 ends rd-
        '{8'h37, 1'b0, 4'd15, 10'h3A9}   // D.23.1
    };

    // rd- forms of the standard 5b/6b and 3b/4b tables
    localparam logic [5:0] CODE6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    localparam logic [3:0] CODE4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };

    logic       clk;
    logic       rst_n;
    logic       din_valid;
    logic [7:0] din;
    logic       k;
    logic       busy;
    logic       ser_valid;
    logic       ser_out;

    logic [9:0] exp_q[$];
    string      name_q[$];
    logic       model_rd;       // 1 = positive
    int         sym_errors;
    int         other_errors;
    int         strobes;
    int         captured;
    int         line_rd;        // ones minus zeros on the line so far
    logic       saw_busy;
    logic [9:0] cap;
    int         nbits;
    logic       prev_valid;
    logic       prev_nonempty;

    line_encoder_top #(
        .FIFO_DEPTH (8)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .din_valid (din_valid),
        .din       (din),
        .k         (k),
        .busy      (busy),
        .ser_valid (ser_valid),
        .ser_out   (ser_out)
    );

    always #CLK_HALF clk = ~clk;

    function automatic string char_name(input logic [7:0] b, input logic kk);
        return $sformatf("%s.%0d.%0d", (kk && b[4:0] == 5'd28) ? "K" : "D", b[4:0], b[7:5]);
    endfunction

    // reference encoder working from code balance and the running disparity
    task automatic encode_model(input logic [7:0] b, input logic kk, output logic [9:0] sym);
        logic [4:0] x;
        logic [2:0] y;
        logic       is_k;
        logic       a7;
        logic [5:0] s6;
        logic [3:0] s4;
        x    = b[4:0];
        y    = b[7:5];
        is_k = kk && (x == 5'd28);
        s6   = is_k ? 6'b001111 : CODE6[x];
        if (model_rd && ($countones(s6) != 3 || s6 == 6'b111000)) begin
            s6 = ~s6;   // rd+ form
        end
        if ($countones(s6) != 3) begin
            model_rd = ~model_rd;
        end
        a7 = (y == 3'd7) && (is_k ||
             (!model_rd && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
             (model_rd && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
        s4 = a7 ? 4'b0111 : CODE4[y];
        if (is_k && $countones(s4) == 2 && s4 != 4'b1100) begin
            if (!model_rd) begin
                s4 = ~s4;   // K28.1 .2 .5 .6 after a negative 6b block
            end
        end else if (model_rd && ($countones(s4) != 2 || s4 == 4'b1100)) begin
            s4 = ~s4;
        end
        if ($countones(s4) != 2) begin
            model_rd = ~model_rd;
        end
        sym = {s6, s4};
    endtask

    // one strobe held off while busy and then the requested idle gap
    task automatic send_char(input logic [7:0] b, input logic kk, input int gap,
                             input logic [9:0] expected, input string tname);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        din_valid = 1'b1;
        din       = b;
        k         = kk;
        exp_q.push_back(expected);
        name_q.push_back(tname);
        strobes++;
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_symbol(input logic [9:0] got);
        logic [9:0] expected;
        string      tname;
        int         diff;
        if (exp_q.size() == 0) begin
            $display("serial symbol %h arrived with no character outstanding", got);
            other_errors++;
        end else begin
            expected = exp_q.pop_front();
            tname    = name_q.pop_front();
            if (got !== expected) begin
                $display("FAILED %s: expected %h, actual %h", tname, expected, got);
                sym_errors++;
            end
        end
        diff = 2 * $countones(got) - 10;
        if (diff != 0 && diff != 2 && diff != -2) begin
            $display("symbol %h has a ones-minus-zeros count of %0d", got, diff);
            other_errors++;
        end
        line_rd += diff;
        if (line_rd != 1 && line_rd != -1) begin
            $display("line disparity reached %0d after symbol %h", line_rd, got);
            other_errors++;
        end
    endtask

    // serial capture and ser_valid continuity sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (busy) begin
                saw_busy = 1'b1;
            end
            if (prev_valid && prev_nonempty && !ser_valid) begin
                $display("ser_valid dropped at %0t while a symbol waited", $time);
                other_errors++;
            end
            if (prev_valid && !ser_valid && nbits != 0) begin
                $display("ser_valid dropped after %0d bits of a symbol", nbits);
                other_errors++;
            end
            if (ser_valid) begin
                cap = {cap[8:0], ser_out};   // bit a arrives first
                nbits++;
                if (nbits == 10) begin
                    nbits = 0;
                    captured++;
                    check_symbol(cap);
                end
            end
            prev_valid    = ser_valid;
            prev_nonempty = !DUT.symbol_ch.empty;
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("timeout after %0d ns with %0d of %0d symbols captured",
                 TIMEOUT_NS, captured, strobes);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [9:0] sym;
        logic [7:0] b;
        void'($urandom(42));
        clk           = 1'b0;
        rst_n         = 1'b0;
        din_valid     = 1'b0;
        din           = 8'h00;
        k             = 1'b0;
        model_rd      = 1'b0;
        line_rd       = -1;
        saw_busy      = 1'b0;
        cap           = '0;
        nbits         = 0;
        prev_valid    = 1'b0;
        prev_nonempty = 1'b0;
        sym_errors    = 0;
        other_errors  = 0;
        strobes       = 0;
        captured      = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (busy || ser_valid) begin
                $display("busy or ser_valid high after reset before any strobe");
                other_errors++;
            end
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < N_TABLE; i++) begin
            encode_model(TABLE[i].b, TABLE[i].kk, sym);
            if (sym !== TABLE[i].sym) begin
                $display("FAILED model %s: expected %h, actual %h",
                         char_name(TABLE[i].b, TABLE[i].kk), TABLE[i].sym, sym);
                sym_errors++;
            end
            send_char(TABLE[i].b, TABLE[i].kk, int'(TABLE[i].gap), TABLE[i].sym,
                      $sformatf("table %s", char_name(TABLE[i].b, TABLE[i].kk)));
        end
        // back to back and only held off by busy
        for (int i = 0; i < N_RANDOM; i++) begin
            b = 8'($urandom);
            encode_model(b, 1'b0, sym);
            send_char(b, 1'b0, 0, sym, $sformatf("random %0d %s", i, char_name(b, 1'b0)));
        end
        while (exp_q.size() != 0 || ser_valid) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        if (ser_valid || busy) begin
            $display("ser_valid or busy still high after the FIFO drained");
            other_errors++;
        end
        if (captured != strobes) begin
            $display("FAILED symbol count: expected %0d, actual %0d", strobes, captured);
            other_errors++;
        end
        if (!saw_busy) begin
            $display("busy never rose during back-to-back strobes");
            other_errors++;
        end
        $display("symbol errors: %0d, other errors: %0d", sym_errors, other_errors);
        if (sym_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
